//--- design/sw_pkg.sv
/*
 * smith-waterman engine shared definitions
 * score, base and position widths, traceback and feeder state encodings
 */
`default_nettype none

package sw_pkg;

    parameter int SCORE_W = 10;     // default signed score width
    parameter int BASE_W  = 2;      // nucleotide code width
    parameter int POS_W   = 8;      // query and target position width

    typedef logic [BASE_W-1:0] base_t;
    typedef logic [POS_W-1:0]  pos_t;

    // origin of a cell's h value
    typedef enum logic [1:0] {
        tr_none = 2'd0,             // clipped at zero or cell inactive
        tr_left = 2'd1,             // gap along the target
        tr_up   = 2'd2,             // gap along the query
        tr_diag = 2'd3              // match or mismatch
    } trace_e;

    // feeder sequencing
    typedef enum logic [1:0] {
        fs_idle   = 2'd0,           // query load, waiting for first target beat
        fs_stream = 2'd1,           // target beats flowing
        fs_drain  = 2'd2,           // pushing the last column down the chain
        fs_report = 2'd3            // waiting for the tracker
    } feed_state_e;

endpackage

`default_nettype wire

//--- design/sw_cell.sv
/*
 * smith-waterman systolic cell
 * holds one query base, scores one target column per step with linear gaps
 * and carries the running local maximum down the chain
 */
`timescale 1ns/1ns
`default_nettype none

module sw_cell #(
    parameter int SCORE_W    = sw_pkg::SCORE_W,
    parameter int CELL_INDEX = 0
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      step,
    input  logic                      first,
    input  logic                      load_strobe,
    input  sw_pkg::base_t             load_base,
    input  logic                      load_active,
    input  logic signed [SCORE_W-1:0] match_score,
    input  logic signed [SCORE_W-1:0] mismatch_score,
    input  logic signed [SCORE_W-1:0] gap_score,
    input  sw_pkg::base_t             base_in,
    input  logic signed [SCORE_W-1:0] h_in,
    input  logic signed [SCORE_W-1:0] max_in,
    input  sw_pkg::pos_t              max_pos_in,
    output sw_pkg::base_t             base_out,
    output logic signed [SCORE_W-1:0] h_out,
    output logic signed [SCORE_W-1:0] max_out,
    output sw_pkg::pos_t              max_pos_out,
    output sw_pkg::trace_e            trace
);
    import sw_pkg::*;

    localparam pos_t MY_POS = pos_t'(CELL_INDEX);

    base_t                     q_base;          // query base held by this cell
    logic                      q_active;        // base lies inside the query
    logic signed [SCORE_W-1:0] h_diag;          // h from above, one column back
    logic signed [SCORE_W-1:0] diag_eff;
    logic signed [SCORE_W-1:0] left_eff;
    logic signed [SCORE_W-1:0] max_stored;
    logic signed [SCORE_W-1:0] sub;
    logic signed [SCORE_W-1:0] cand_diag;
    logic signed [SCORE_W-1:0] cand_up;
    logic signed [SCORE_W-1:0] cand_left;
    logic signed [SCORE_W-1:0] h_next;
    logic signed [SCORE_W-1:0] max_next;
    pos_t                      pos_next;
    trace_e                    tr_next;

    ////////////////////
    // scoring
    ////////////////////
    // column 0 sees zero to the left and on the diagonal
    assign diag_eff   = first ? '0 : h_diag;
    assign left_eff   = first ? '0 : h_out;     // own h is H(i,j-1)
    assign max_stored = first ? '0 : max_out;   // new target restarts the max

    assign sub       = (q_base == base_in) ? match_score : mismatch_score;
    assign cand_diag = diag_eff + sub;
    assign cand_up   = h_in + gap_score;
    assign cand_left = left_eff + gap_score;

    always_comb begin
        h_next  = '0;                   // local clip floor
        tr_next = tr_none;
        if (!q_active) begin
            h_next = h_in;              // past the query end, just pass h down
        end else begin
            if (cand_diag > h_next) begin
                h_next  = cand_diag;
                tr_next = tr_diag;
            end
            if (cand_up > h_next) begin
                h_next  = cand_up;
                tr_next = tr_up;
            end
            if (cand_left > h_next) begin
                h_next  = cand_left;
                tr_next = tr_left;
            end
        end
    end

    // tie order above, stored, new keeps the lowest query position
    always_comb begin
        if (max_in >= max_stored && max_in >= h_next) begin
            max_next = max_in;
            pos_next = max_pos_in;
        end else if (max_stored >= h_next) begin
            max_next = max_stored;
            pos_next = max_pos_out;
        end else begin
            max_next = h_next;
            pos_next = MY_POS;
        end
    end

    ////////////////////
    // registers
    ////////////////////
    always_ff @(posedge clk) begin
        if (load_strobe) begin
            q_base <= load_base;
        end
        if (step) begin
            base_out <= base_in;        // target base moves to the next cell
            h_diag   <= h_in;           // becomes the diagonal next column
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            q_active    <= 1'b0;
            h_out       <= '0;
            max_out     <= '0;
            max_pos_out <= '0;
            trace       <= tr_none;
        end else begin
            if (load_strobe) begin
                q_active <= load_active;
            end
            if (step) begin
                h_out       <= h_next;
                max_out     <= max_next;
                max_pos_out <= pos_next;
                trace       <= tr_next;
            end
        end
    end

    // holds for inactive cells too, since they forward h from above
    a_h_nonneg: assert property (@(posedge clk) disable iff (rst)
        !h_out[SCORE_W-1])
        else $error("cell %0d produced a negative h", CELL_INDEX);

endmodule

`default_nettype wire

//--- design/sw_array.sv
/*
 * smith-waterman systolic array
 * chain of scoring cells, control flags skewed one register per cell
 */
`timescale 1ns/1ns
`default_nettype none

module sw_array #(
    parameter int NUM_CELLS = 8,
    parameter int SCORE_W   = sw_pkg::SCORE_W
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      step,
    input  sw_pkg::base_t             col_base,
    input  logic                      col_first,
    input  logic                      col_last,
    input  logic [NUM_CELLS-1:0]      load_strobe,
    input  sw_pkg::base_t             load_base,
    input  logic                      load_active,
    input  logic signed [SCORE_W-1:0] match_score,
    input  logic signed [SCORE_W-1:0] mismatch_score,
    input  logic signed [SCORE_W-1:0] gap_score,
    output logic                      last_step,
    output logic                      last_first,
    output logic                      last_last,
    output logic signed [SCORE_W-1:0] last_max,
    output sw_pkg::pos_t              last_max_pos,
    output sw_pkg::trace_e            last_trace
);
    import sw_pkg::*;

    logic [NUM_CELLS-1:0]      step_q, first_q, last_q;    // flag after cell i
    logic [NUM_CELLS:0]        step_v, first_v, last_v;    // flag into cell i
    base_t                     base_ch [NUM_CELLS+1];
    logic signed [SCORE_W-1:0] h_ch    [NUM_CELLS+1];
    logic signed [SCORE_W-1:0] max_ch  [NUM_CELLS+1];
    pos_t                      pos_ch  [NUM_CELLS+1];
    trace_e                    tr_ch   [NUM_CELLS];

    assign step_v  = {step_q, step};
    assign first_v = {first_q, col_first};
    assign last_v  = {last_q, col_last};

    // top of the matrix
    assign base_ch[0] = col_base;
    assign h_ch[0]    = '0;
    assign max_ch[0]  = '0;
    assign pos_ch[0]  = '0;

    // flags trail the base so each cell sees its own column
    always_ff @(posedge clk) begin
        if (rst) begin
            step_q  <= '0;
            first_q <= '0;
            last_q  <= '0;
        end else begin
            step_q  <= step_v[NUM_CELLS-1:0];
            first_q <= first_v[NUM_CELLS-1:0];
            last_q  <= last_v[NUM_CELLS-1:0];
        end
    end

    for (genvar i = 0; i < NUM_CELLS; i++) begin : g_cell
        sw_cell #(
            .SCORE_W    (SCORE_W),
            .CELL_INDEX (i)
        ) cell0 (
            .clk            (clk),
            .rst            (rst),
            .step           (step_v[i]),
            .first          (first_v[i]),
            .load_strobe    (load_strobe[i]),
            .load_base      (load_base),
            .load_active    (load_active),
            .match_score    (match_score),
            .mismatch_score (mismatch_score),
            .gap_score      (gap_score),
            .base_in        (base_ch[i]),
            .h_in           (h_ch[i]),
            .max_in         (max_ch[i]),
            .max_pos_in     (pos_ch[i]),
            .base_out       (base_ch[i+1]),
            .h_out          (h_ch[i+1]),
            .max_out        (max_ch[i+1]),
            .max_pos_out    (pos_ch[i+1]),
            .trace          (tr_ch[i])
        );
    end

    // flags line up with the last cell's registered outputs
    assign last_step    = step_q[NUM_CELLS-1];
    assign last_first   = first_q[NUM_CELLS-1];
    assign last_last    = last_q[NUM_CELLS-1];
    assign last_max     = max_ch[NUM_CELLS];
    assign last_max_pos = pos_ch[NUM_CELLS];
    assign last_trace   = tr_ch[NUM_CELLS-1];

endmodule

`default_nettype wire

//--- design/sw_feeder.sv
/*
 * smith-waterman feeder
 * loads query bases into the cells and turns target beats into array steps
 */
`timescale 1ns/1ns
`default_nettype none

module sw_feeder #(
    parameter int NUM_CELLS = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 query_valid,
    input  sw_pkg::base_t        query_base,
    input  logic                 query_last,
    output logic                 query_ready,
    input  logic                 target_valid,
    input  sw_pkg::base_t        target_base,
    input  logic                 target_last,
    output logic                 target_ready,
    input  logic                 report_done,
    output logic                 step,
    output sw_pkg::base_t        col_base,
    output logic                 col_first,
    output logic                 col_last,
    output logic [NUM_CELLS-1:0] load_strobe,
    output sw_pkg::base_t        load_base,
    output logic                 load_active
);
    import sw_pkg::*;

    localparam pos_t LAST_CELL = pos_t'(NUM_CELLS - 1);

    feed_state_e state;
    pos_t        q_cnt;                 // next cell to load or clear
    logic        sweep;                 // clearing cells past the query end
    logic        q_loaded;              // a complete query sits in the array
    pos_t        drain_cnt;
    logic        q_fire;
    logic        t_fire;

    assign query_ready  = (state == fs_idle) && !sweep;
    assign target_ready = ((state == fs_idle) && q_loaded) || (state == fs_stream);
    assign q_fire       = query_valid && query_ready;
    assign t_fire       = target_valid && target_ready;

    ////////////////////
    // query load
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            q_cnt       <= '0;
            sweep       <= 1'b0;
            q_loaded    <= 1'b0;
            load_strobe <= '0;
        end else begin
            load_strobe <= '0;
            if (q_fire) begin
                load_strobe <= NUM_CELLS'(1) << q_cnt;
                load_base   <= query_base;
                load_active <= 1'b1;
                q_loaded    <= query_last;      // cleared while a new query is half loaded
                if (query_last && q_cnt == LAST_CELL) begin
                    q_cnt <= '0;                // array full, nothing to clear
                end else begin
                    q_cnt <= q_cnt + 1'b1;
                    sweep <= query_last;
                end
            end else if (sweep) begin
                // one unused cell per cycle, stays ahead of the first column
                load_strobe <= NUM_CELLS'(1) << q_cnt;
                load_active <= 1'b0;
                if (q_cnt == LAST_CELL) begin
                    q_cnt <= '0;
                    sweep <= 1'b0;
                end else begin
                    q_cnt <= q_cnt + 1'b1;
                end
            end
        end
    end

    ////////////////////
    // target sequencing
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= fs_idle;
            drain_cnt <= '0;
            step      <= 1'b0;
            col_first <= 1'b0;
            col_last  <= 1'b0;
        end else begin
            step      <= t_fire || (state == fs_drain);  // drain steps carry no base
            col_first <= t_fire && (state == fs_idle);
            col_last  <= t_fire && target_last;
            col_base  <= t_fire ? target_base : '0;
            case (state)
                fs_idle, fs_stream: begin
                    if (t_fire) begin
                        state     <= target_last ? fs_drain : fs_stream;
                        drain_cnt <= '0;
                    end
                end
                fs_drain: begin
                    if (drain_cnt == pos_t'(NUM_CELLS - 2)) begin
                        state <= fs_report;     // NUM_CELLS-1 drain cycles done
                    end
                    drain_cnt <= drain_cnt + 1'b1;
                end
                default: begin
                    if (report_done) begin
                        state <= fs_idle;
                    end
                end
            endcase
        end
    end

    // a load or sweep cycle must hit exactly one existing cell
    a_strobe_onehot: assert property (@(posedge clk) disable iff (rst)
        (q_fire || sweep) |=> $onehot(load_strobe))
        else $error("load_strobe not one-hot after a load or sweep cycle");

    a_query_len: assert property (@(posedge clk) disable iff (rst)
        q_fire && (q_cnt == LAST_CELL) |-> query_last)
        else $error("query longer than %0d bases", NUM_CELLS);

endmodule

`default_nettype wire

//--- design/sw_result_tracker.sv
/*
 * smith-waterman result tracker
 * follows the running max at the last cell and reports the best alignment
 */
`timescale 1ns/1ns
`default_nettype none

module sw_result_tracker #(
    parameter int SCORE_W = sw_pkg::SCORE_W
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      last_step,
    input  logic                      last_first,
    input  logic                      last_last,
    input  logic signed [SCORE_W-1:0] last_max,
    input  sw_pkg::pos_t              last_max_pos,
    output logic                      result_valid,
    output logic signed [SCORE_W-1:0] result_score,
    output sw_pkg::pos_t              result_query_pos,
    output sw_pkg::pos_t              result_target_pos,
    output logic                      report_done
);
    import sw_pkg::*;

    pos_t                      col_cnt;     // column now leaving the last cell
    pos_t                      cur_col;
    logic signed [SCORE_W-1:0] best;
    pos_t                      best_col;    // first column reaching best
    logic signed [SCORE_W-1:0] next_best;
    pos_t                      next_col;

    always_comb begin
        cur_col   = last_first ? '0 : col_cnt + 1'b1;
        next_best = best;
        next_col  = best_col;
        // only a strict rise moves the column, so the earliest one wins
        if (last_first || last_max > best) begin
            next_best = last_max;
            next_col  = cur_col;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            col_cnt      <= '0;
            best         <= '0;
            best_col     <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= last_step && last_last;     // one cycle pulse
            if (last_step) begin
                col_cnt  <= cur_col;
                best     <= next_best;
                best_col <= next_col;
            end
        end
    end

    // result held until the next target completes
    always_ff @(posedge clk) begin
        if (last_step && last_last) begin
            result_score      <= next_best;
            result_query_pos  <= last_max_pos;
            result_target_pos <= next_col;
        end
    end

    assign report_done = result_valid;      // releases the feeder from report

endmodule

`default_nettype wire

//--- design/sw_top.sv
/*
 * smith-waterman local alignment engine
 * feeder, systolic array and result tracker with linear gap scoring
 */
`timescale 1ns/1ns
`default_nettype none

module sw_top #(
    parameter int NUM_CELLS = 8,
    parameter int SCORE_W   = sw_pkg::SCORE_W
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      query_valid,
    input  sw_pkg::base_t             query_base,
    input  logic                      query_last,
    output logic                      query_ready,
    input  logic                      target_valid,
    input  sw_pkg::base_t             target_base,
    input  logic                      target_last,
    output logic                      target_ready,
    input  logic signed [SCORE_W-1:0] match_score,     // stable while a target is in flight
    input  logic signed [SCORE_W-1:0] mismatch_score,
    input  logic signed [SCORE_W-1:0] gap_score,
    output logic                      result_valid,
    output logic signed [SCORE_W-1:0] result_score,
    output sw_pkg::pos_t              result_query_pos,
    output sw_pkg::pos_t              result_target_pos,
    output sw_pkg::trace_e            trace_out
);
    import sw_pkg::*;

    logic                      step, col_first, col_last;
    base_t                     col_base;
    logic [NUM_CELLS-1:0]      load_strobe;
    base_t                     load_base;
    logic                      load_active;
    logic                      last_step, last_first, last_last;
    logic signed [SCORE_W-1:0] last_max;
    pos_t                      last_max_pos;
    logic                      report_done;

    sw_feeder #(.NUM_CELLS(NUM_CELLS)) feeder0 (
        .clk(clk), .rst(rst),
        .query_valid(query_valid), .query_base(query_base), .query_last(query_last),
        .query_ready(query_ready),
        .target_valid(target_valid), .target_base(target_base), .target_last(target_last),
        .target_ready(target_ready), .report_done(report_done),
        .step(step), .col_base(col_base), .col_first(col_first), .col_last(col_last),
        .load_strobe(load_strobe), .load_base(load_base), .load_active(load_active)
    );

    sw_array #(.NUM_CELLS(NUM_CELLS), .SCORE_W(SCORE_W)) array0 (
        .clk(clk), .rst(rst),
        .step(step), .col_base(col_base), .col_first(col_first), .col_last(col_last),
        .load_strobe(load_strobe), .load_base(load_base), .load_active(load_active),
        .match_score(match_score), .mismatch_score(mismatch_score), .gap_score(gap_score),
        .last_step(last_step), .last_first(last_first), .last_last(last_last),
        .last_max(last_max), .last_max_pos(last_max_pos), .last_trace(trace_out)
    );

    sw_result_tracker #(.SCORE_W(SCORE_W)) tracker0 (
        .clk(clk), .rst(rst),
        .last_step(last_step), .last_first(last_first), .last_last(last_last),
        .last_max(last_max), .last_max_pos(last_max_pos),
        .result_valid(result_valid), .result_score(result_score),
        .result_query_pos(result_query_pos), .result_target_pos(result_target_pos),
        .report_done(report_done)
    );

    // feeder register, one skew stage per cell, tracker register
    a_result_latency: assert property (@(posedge clk) disable iff (rst)
        target_valid && target_ready && target_last |-> ##(NUM_CELLS+2) result_valid)
        else $error("result not NUM_CELLS+1 cycles after target_last");

endmodule

`default_nettype wire

//--- tests/sw_model.svh
/*
 * smith-waterman reference for the testbench
 * fills the whole local alignment matrix and locates the best score
 */
`ifndef SW_MODEL_SVH
`define SW_MODEL_SVH
`default_nettype none

// reads qry, tgt and the three score inputs of the enclosing testbench
task automatic model_align(input int qlen, input int tlen,
                           output int best, output int best_i, output int best_j);
    int h [MAX_Q+1][MAX_T+1];           // row 0 and column 0 are the zero border
    int i;
    int j;
    int sub;
    int diag;
    int up;
    int left;
    for (i = 0; i <= qlen; i++) begin
        for (j = 0; j <= tlen; j++) begin
            h[i][j] = 0;
        end
    end
    best = 0;
    for (i = 1; i <= qlen; i++) begin
        for (j = 1; j <= tlen; j++) begin
            sub  = (qry[i-1] == tgt[j-1]) ? int'(match_score) : int'(mismatch_score);
            diag = h[i-1][j-1] + sub;
            up   = h[i-1][j] + int'(gap_score);
            left = h[i][j-1] + int'(gap_score);
            if (diag > h[i][j]) h[i][j] = diag;     // floor of zero already in place
            if (up > h[i][j]) h[i][j] = up;
            if (left > h[i][j]) h[i][j] = left;
            if (h[i][j] > best) best = h[i][j];
        end
    end
    // lowest row and lowest column holding the best score, taken apart
    best_i = 0;
    best_j = 0;
    if (best > 0) begin
        best_i = qlen;
        best_j = tlen;
        for (i = 1; i <= qlen; i++) begin
            for (j = 1; j <= tlen; j++) begin
                if (h[i][j] == best && i - 1 < best_i) best_i = i - 1;
                if (h[i][j] == best && j - 1 < best_j) best_j = j - 1;
            end
        end
    end
endtask

`default_nettype wire
`endif

//--- tests/sw_tb.sv
/*
 * smith-waterman engine testbench
 * directed alignment cases checked against a full matrix reference
 */
`timescale 1ns/1ns
`default_nettype none

module sw_tb;
    import sw_pkg::*;

    localparam int NUM_CELLS = 8;
    localparam int MAX_Q     = NUM_CELLS;
    localparam int MAX_T     = 20;
    localparam int NUM_CASES = 9;           // alignments run over all tests
    // query load, target with gaps, latency and some slack per case
    localparam int TIMEOUT_CYCLES = NUM_CASES * (MAX_Q + 3 * MAX_T + NUM_CELLS + 12) + 64;

    logic                      clk;
    logic                      rst;
    logic                      query_valid, query_last, query_ready;
    base_t                     query_base;
    logic                      target_valid, target_last, target_ready;
    base_t                     target_base;
    logic signed [SCORE_W-1:0] match_score, mismatch_score, gap_score;
    logic                      result_valid;
    logic signed [SCORE_W-1:0] result_score;
    pos_t                      result_query_pos, result_target_pos;
    trace_e                    trace_out;

    base_t       qry [MAX_Q];               // sequences shared with the model
    base_t       tgt [MAX_T];
    logic [31:0] lfsr;
    int          cyc = 0;
    int          errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          got_score, got_qpos, got_tpos, got_lat;

    sw_top #(
        .NUM_CELLS (NUM_CELLS),
        .SCORE_W   (SCORE_W)
    ) dut0 (
        .clk               (clk),
        .rst               (rst),
        .query_valid       (query_valid),
        .query_base        (query_base),
        .query_last        (query_last),
        .query_ready       (query_ready),
        .target_valid      (target_valid),
        .target_base       (target_base),
        .target_last       (target_last),
        .target_ready      (target_ready),
        .match_score       (match_score),
        .mismatch_score    (mismatch_score),
        .gap_score         (gap_score),
        .result_valid      (result_valid),
        .result_score      (result_score),
        .result_query_pos  (result_query_pos),
        .result_target_pos (result_target_pos),
        .trace_out         (trace_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", cyc);
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////
    // stimulus helpers
    ////////////////////
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];    // x^32+x^22+x^2+x+1
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        int b;
        v = 0;
        for (b = 0; b < n; b++) begin
            v = (v << 1) | int'(lfsr_step());
        end
        return v;
    endfunction

    task automatic reset_dut();
        @(posedge clk);
        rst          <= 1'b1;
        query_valid  <= 1'b0;
        query_last   <= 1'b0;
        target_valid <= 1'b0;
        target_last  <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    endtask

    // scores only change between targets
    task automatic set_scores(input int m, input int mm, input int g);
        @(posedge clk);
        match_score    <= m;
        mismatch_score <= mm;
        gap_score      <= g;
    endtask

    task automatic load_query(input int len);
        int   k;
        logic acc;
        k = 0;
        @(posedge clk);
        while (k < len) begin
            query_valid <= 1'b1;
            query_base  <= qry[k];
            query_last  <= (k == len - 1);
            @(negedge clk);
            acc = query_ready;              // beat moves on the coming edge
            @(posedge clk);
            if (acc) k++;
        end
        query_valid <= 1'b0;
        query_last  <= 1'b0;
    endtask

    task automatic send_target(input int len, input bit gaps);
        int   k;
        logic acc;
        k = 0;
        @(posedge clk);
        while (k < len) begin
            if (gaps && rand_bits(2) == 0) begin
                target_valid <= 1'b0;       // idle slot, array must hold
                acc = 1'b0;
            end else begin
                target_valid <= 1'b1;
                target_base  <= tgt[k];
                target_last  <= (k == len - 1);
                acc = 1'b1;
            end
            @(negedge clk);
            acc = acc && target_ready;
            if (k > 0 && query_ready) begin
                $display("error: query_ready high while a target is streaming");
                errors++;
            end
            @(posedge clk);
            if (acc) k++;
        end
        target_valid <= 1'b0;
        target_last  <= 1'b0;
    endtask

    // called right at the edge that took target_last
    task automatic wait_result();
        int start;
        int n;
        @(negedge clk);
        start = cyc;
        n = 0;
        while (!result_valid && n < NUM_CELLS + 20) begin
            @(negedge clk);
            n++;
        end
        if (!result_valid) begin
            $display("error: no result_valid pulse after the last target beat");
            errors++;
        end
        got_lat   = cyc - start;
        got_score = result_score;           // sign extends
        got_qpos  = result_query_pos;
        got_tpos  = result_target_pos;
    endtask

    ////////////////////
    // checks
    ////////////////////
    task automatic expect_eq(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_result(input int qlen, input int tlen);
        int e_score;
        int e_qpos;
        int e_tpos;
        model_align(qlen, tlen, e_score, e_qpos, e_tpos);
        expect_eq("result_score", got_score, e_score);
        expect_eq("result_query_pos", got_qpos, e_qpos);
        expect_eq("result_target_pos", got_tpos, e_tpos);
        expect_eq("result latency", got_lat, NUM_CELLS + 1);
    endtask

    task automatic run_case(input int qlen, input int tlen, input bit gaps);
        load_query(qlen);
        send_target(tlen, gaps);
        wait_result();
        check_result(qlen, tlen);
    endtask

    task automatic fill_random(input int qlen, input int tlen);
        int k;
        for (k = 0; k < qlen; k++) qry[k] = base_t'(rand_bits(2));
        for (k = 0; k < tlen; k++) tgt[k] = base_t'(rand_bits(2));
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        if (errors == err_before) begin
            $display("test %0d %s: pass", num, name);
            tests_passed++;
        end else begin
            $display("test %0d %s: FAIL with %0d errors", num, name, errors - err_before);
            tests_failed++;
        end
    endtask

    ////////////////////
    // directed tests
    ////////////////////
    task automatic identical_seq();
        int e0;
        int k;
        e0 = errors;
        set_scores(2, -1, -2);
        for (k = 0; k < MAX_Q; k++) begin
            qry[k] = base_t'(rand_bits(2));
            tgt[k] = qry[k];
        end
        run_case(MAX_Q, MAX_Q, 1'b0);
        expect_eq("result_score", got_score, MAX_Q * 2);    // full diagonal
        expect_eq("result_query_pos", got_qpos, MAX_Q - 1);
        expect_eq("result_target_pos", got_tpos, MAX_Q - 1);
        report_test(1, "identical query and target", e0);
    endtask

    task automatic random_seqs();
        int e0;
        e0 = errors;
        repeat (3) begin
            fill_random(MAX_Q, MAX_T);
            run_case(MAX_Q, MAX_T, 1'b0);
        end
        report_test(2, "random sequences", e0);
    endtask

    task automatic short_query();
        int e0;
        e0 = errors;
        fill_random(3, 12);                 // cells 3 and up were active before
        run_case(3, 12, 1'b0);
        report_test(3, "short query", e0);
    endtask

    task automatic gapped_stream();
        int e0;
        int s_score;
        int s_qpos;
        int s_tpos;
        e0 = errors;
        set_scores(3, -2, -1);
        fill_random(MAX_Q, 16);
        run_case(MAX_Q, 16, 1'b0);
        s_score = got_score;
        s_qpos  = got_qpos;
        s_tpos  = got_tpos;
        run_case(MAX_Q, 16, 1'b1);          // same sequences with valid gaps
        expect_eq("result_score vs no gaps", got_score, s_score);
        expect_eq("result_query_pos vs no gaps", got_qpos, s_qpos);
        expect_eq("result_target_pos vs no gaps", got_tpos, s_tpos);
        report_test(4, "target_valid gaps", e0);
    endtask

    task automatic all_mismatch();
        int e0;
        int k;
        e0 = errors;
        set_scores(1, -2, -1);
        for (k = 0; k < MAX_Q; k++) qry[k] = 2'd0;
        for (k = 0; k < MAX_T; k++) tgt[k] = base_t'(rand_bits(2) % 3 + 1);  // never 0
        run_case(MAX_Q, MAX_T, 1'b0);
        expect_eq("result_score", got_score, 0);
        expect_eq("result_query_pos", got_qpos, 0);
        expect_eq("result_target_pos", got_tpos, 0);
        report_test(5, "full mismatch", e0);
    endtask

    task automatic handshake();
        int e0;
        e0 = errors;
        reset_dut();
        @(negedge clk);
        if (!query_ready) begin
            $display("error: query_ready low after reset");
            errors++;
        end
        if (target_ready) begin
            $display("error: target_ready high before a query was loaded");
            errors++;
        end
        if (result_valid) begin
            $display("error: result_valid high after reset");
            errors++;
        end
        expect_eq("trace_out", trace_out, tr_none);
        // a target offered with no query must sit unaccepted
        @(posedge clk);
        target_valid <= 1'b1;
        target_base  <= 2'd1;
        target_last  <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            if (target_ready) begin
                $display("error: target accepted before any query was loaded");
                errors++;
            end
            @(posedge clk);
        end
        target_valid <= 1'b0;
        target_last  <= 1'b0;
        fill_random(5, 10);
        run_case(5, 10, 1'b0);              // latency and query_ready checked inside
        report_test(6, "handshake", e0);
    endtask

    initial begin
        rst            <= 1'b1;
        query_valid    <= 1'b0;
        query_base     <= '0;
        query_last     <= 1'b0;
        target_valid   <= 1'b0;
        target_base    <= '0;
        target_last    <= 1'b0;
        match_score    <= '0;
        mismatch_score <= '0;
        gap_score      <= '0;
        lfsr = 32'h578e_0f11;
        reset_dut();
        identical_seq();
        random_seqs();
        short_query();
        gapped_stream();
        all_mismatch();
        handshake();
        $display("summary: %0d passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    `include "sw_model.svh"

endmodule

`default_nettype wire

//--- src.f
+incdir+tests
design/sw_pkg.sv
design/sw_cell.sv
design/sw_array.sv
design/sw_feeder.sv
design/sw_result_tracker.sv
design/sw_top.sv
tests/sw_tb.sv
